//--- imuldiv.f
common/imuldiv_cfg_pkg.sv
common/imuldiv_msg_pkg.sv
div/imuldiv_int_div_ctrl.sv
div/imuldiv_int_div_dpath.sv
div/imuldiv_int_div_iterative.sv
hw/imuldiv_int_mul_iterative.sv
hw/imuldiv_dispatch.sv
hw/imuldiv_top.sv
testbench/imuldiv_props.sv
testbench/imuldiv_tb.sv

//--- Bender.yml
package:
  name: imuldiv

sources:
  - common/imuldiv_cfg_pkg.sv
  - common/imuldiv_msg_pkg.sv
  - div/imuldiv_int_div_ctrl.sv
  - div/imuldiv_int_div_dpath.sv
  - div/imuldiv_int_div_iterative.sv
  - hw/imuldiv_int_mul_iterative.sv
  - hw/imuldiv_dispatch.sv
  - hw/imuldiv_top.sv
  - target: test
    files:
      - testbench/imuldiv_props.sv
      - testbench/imuldiv_tb.sv

//--- testbench/imuldiv_tb.sv
/* imuldiv testbench
   directed table and LFSR-driven operations with random response back-pressure */

module imuldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;

  // one table row, request plus the expected result word
  typedef struct packed {
    muldiv_req_t             req;
    logic [result_width-1:0] expected;
  } row_t;

  localparam int num_random = 200;

  logic           clk;
  logic           reset;
  muldiv_req_t    req_msg;
  logic           req_val;
  logic           req_rdy;
  muldiv_result_u resp_msg;
  logic           resp_val;
  logic           resp_rdy;

  row_t                    table_q[$];
  logic [result_width-1:0] expect_q[$];
  logic [31:0]             lfsr_state;
  int                      issued;
  int                      received;
  int                      cycles;
  int                      timeout_limit;

  imuldiv_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  bind imuldiv_top imuldiv_props props0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, want);
      stop_run();
    end
  endtask

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic add_row(input muldiv_fn_e fn, input logic [31:0] a,
                         input logic [31:0] b, input logic [63:0] expected);
    row_t r;
    r.req.fn   = fn;
    r.req.a    = a;
    r.req.b    = b;
    r.expected = expected;
    table_q.push_back(r);
  endtask

  // reference result from the arithmetic rules, 64-bit math avoids overflow
  function automatic logic [63:0] model_result(input muldiv_req_t r);
    longint sa;
    longint sb;
    longint sq;
    longint sr;
    logic [31:0] q;
    logic [31:0] rm;
    sa = longint'($signed(r.a));
    sb = longint'($signed(r.b));
    case (r.fn)
      fn_mul: return sa * sb;
      fn_div: begin
        sq = sa / sb;
        sr = sa % sb;
        return {sr[31:0], sq[31:0]};
      end
      default: begin
        q  = r.a / r.b;
        rm = r.a % r.b;
        return {rm, q};
      end
    endcase
  endfunction

  // random op, divisors shifted down for larger quotients and kept nonzero
  task automatic make_random_op(output muldiv_req_t m);
    logic [31:0] bits;
    logic [31:0] sh;
    take_bits(2, bits);
    case (bits[1:0])
      2'd1:    m.fn = fn_div;
      2'd2:    m.fn = fn_divu;
      default: m.fn = fn_mul;
    endcase
    take_bits(32, bits);
    m.a = bits;
    take_bits(32, bits);
    m.b = bits;
    if (m.fn != fn_mul) begin
      take_bits(5, sh);
      if (m.fn == fn_div) begin
        m.b = $signed(m.b) >>> sh[4:0];
      end else begin
        m.b = m.b >> sh[4:0];
      end
      if (m.b == '0) begin
        m.b = 32'd1;
      end
    end
  endtask

  // hold the request until the DUT takes it, returns at the negedge before the accept
  task automatic issue_op(input muldiv_req_t m, input logic [63:0] want);
    @(posedge clk);
    #1;
    req_msg = m;
    req_val = 1'b1;
    do @(negedge clk); while (!req_rdy);
    expect_q.push_back(want);
    issued++;
  endtask

  // ----------------------------------------
  // directed table
  // ----------------------------------------

  task automatic load_table();
    // signed multiply
    add_row(fn_mul,  32'h0000_0007, 32'h0000_0006, 64'h0000_0000_0000_002a);
    add_row(fn_mul,  32'hffff_fffd, 32'h0000_0005, 64'hffff_ffff_ffff_fff1);
    add_row(fn_mul,  32'hffff_fffc, 32'hffff_fff7, 64'h0000_0000_0000_0024);
    add_row(fn_mul,  32'h0000_0000, 32'h0000_3039, 64'h0000_0000_0000_0000);
    add_row(fn_mul,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000);
    add_row(fn_mul,  32'h7fff_ffff, 32'h7fff_ffff, 64'h3fff_ffff_0000_0001);
    add_row(fn_mul,  32'h8000_0000, 32'h7fff_ffff, 64'hc000_0000_8000_0000);
    // signed divide, result is {rem, quot}
    add_row(fn_div,  32'h0000_0014, 32'h0000_0003, 64'h0000_0002_0000_0006);
    add_row(fn_div,  32'hffff_ffec, 32'h0000_0003, 64'hffff_fffe_ffff_fffa);
    add_row(fn_div,  32'h0000_0014, 32'hffff_fffd, 64'h0000_0002_ffff_fffa);
    add_row(fn_div,  32'hffff_ffec, 32'hffff_fffd, 64'hffff_fffe_0000_0006);
    add_row(fn_div,  32'h0000_0005, 32'h0000_0009, 64'h0000_0005_0000_0000);
    add_row(fn_div,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000);
    // unsigned divide with the top bit set
    add_row(fn_divu, 32'hffff_ffff, 32'h0000_0010, 64'h0000_000f_0fff_ffff);
    add_row(fn_divu, 32'h8000_0000, 32'h0000_0003, 64'h0000_0002_2aaa_aaaa);
    add_row(fn_divu, 32'h0000_0005, 32'h8000_0000, 64'h0000_0005_0000_0000);
    add_row(fn_divu, 32'hffff_fff0, 32'hffff_ffff, 64'hffff_fff0_0000_0000);
    add_row(fn_divu, 32'hffff_ffff, 32'h8000_0000, 64'h7fff_ffff_0000_0001);
  endtask

  // ----------------------------------------
  // clock, back-pressure, checker, timeout
  // ----------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // one LFSR bit per cycle for resp_rdy
  initial begin
    logic [31:0] bit_v;
    wait (reset === 1'b0);
    forever begin
      @(posedge clk);
      #1;
      take_bits(1, bit_v);
      resp_rdy = bit_v[0];
    end
  end

  // val and rdy seen at the negedge mean a transfer on the next rising edge
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (expect_q.size() == 0) begin
        $display("response arrived at %0t with no request outstanding", $time);
        stop_run();
      end else begin
        check_value("resp_msg", resp_msg, expect_q.pop_front());
        received++;
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > timeout_limit) begin
        $display("timeout after %0d cycles, %0d of %0d responses received",
                 cycles, received, issued);
        stop_run();
      end
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    muldiv_req_t m;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_msg    = '0;
    resp_rdy   = 1'b0;
    lfsr_state = 32'h53d4_81ce;
    issued     = 0;
    received   = 0;
    load_table();
    timeout_limit = (table_q.size() + num_random) * 40 + 100;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (table_q[i]) begin
      issue_op(table_q[i].req, table_q[i].expected);
    end
    for (int i = 0; i < num_random; i++) begin
      make_random_op(m);
      issue_op(m, model_result(m));
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
    // drain outstanding responses
    while (received < issued) begin
      @(negedge clk);
    end
    // a repeated response or a stuck busy flag shows up here
    repeat (4) @(negedge clk);
    if (resp_val || !req_rdy) begin
      $display("DUT not idle after the last response, resp_val=%b req_rdy=%b",
               resp_val, req_rdy);
      stop_run();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- testbench/imuldiv_props.sv
/* imuldiv handshake properties
   response stability, request blocking and post-reset state of the top level */

module imuldiv_props (
  input logic                            clk,
  input logic                            reset,
  input logic                            req_val,
  input logic                            req_rdy,
  input imuldiv_msg_pkg::muldiv_result_u resp_msg,
  input logic                            resp_val,
  input logic                            resp_rdy
);

  timeunit 1ns;
  timeprecision 100ps;

  // operation accepted and not yet answered, seen from the outside ports
  logic outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (req_val && req_rdy) begin
      outstanding <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      outstanding <= 1'b0;
    end
  end

  // a response under back-pressure must hold its valid and its word
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else $error("response changed before its transfer");

  // no new request is taken while an operation waits for its response
  req_blocked: assert property (@(posedge clk) disable iff (reset)
    outstanding |-> !req_rdy)
    else $error("req_rdy high while an operation is outstanding");

  // first cycle out of reset, idle and ready
  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> !resp_val && req_rdy)
    else $error("unexpected handshake state after reset");

endmodule

//--- hw/imuldiv_top.sv
/* imuldiv top level
   dispatcher in front of the iterative multiplier and divider */

module imuldiv_top (
  input  logic                           clk,
  input  logic                           reset,
  input  imuldiv_msg_pkg::muldiv_req_t    req_msg,
  input  logic                           req_val,
  output logic                           req_rdy,
  output imuldiv_msg_pkg::muldiv_result_u resp_msg,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  import imuldiv_msg_pkg::*;

  // multiplier side
  logic           mul_req_val;
  logic           mul_req_rdy;
  muldiv_result_u mul_resp_msg;
  logic           mul_resp_val;
  logic           mul_resp_rdy;

  // divider side
  logic           div_req_val;
  logic           div_req_rdy;
  muldiv_result_u div_resp_msg;
  logic           div_resp_val;
  logic           div_resp_rdy;

  // ----------------------------------------
  // steering
  // ----------------------------------------

  imuldiv_dispatch dispatch0 (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_msg     (resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_resp_msg (div_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy)
  );

  // ----------------------------------------
  // units, operands shared by both
  // ----------------------------------------

  imuldiv_int_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_msg (mul_resp_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_int_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_msg (div_resp_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

//--- hw/imuldiv_dispatch.sv
/* imuldiv dispatcher
   routes a request to the unit picked by fn and returns that unit's response */

module imuldiv_dispatch (
  input  logic                            clk,
  input  logic                            reset,
  input  imuldiv_msg_pkg::muldiv_req_t     req_msg,
  input  logic                            req_val,
  output logic                            req_rdy,
  output imuldiv_msg_pkg::muldiv_result_u  resp_msg,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output logic                            mul_req_val,
  input  logic                            mul_req_rdy,
  input  imuldiv_msg_pkg::muldiv_result_u  mul_resp_msg,
  input  logic                            mul_resp_val,
  output logic                            mul_resp_rdy,
  output logic                            div_req_val,
  input  logic                            div_req_rdy,
  input  imuldiv_msg_pkg::muldiv_result_u  div_resp_msg,
  input  logic                            div_resp_val,
  output logic                            div_resp_rdy
);

  import imuldiv_msg_pkg::*;

  // one operation outstanding at most
  logic busy;
  // owner of the outstanding operation, 1 means divider
  logic owner;
  logic sel_div;

  // both divide codes go to the divider
  assign sel_div = (req_msg.fn == fn_div) || (req_msg.fn == fn_divu);

  // ----------------------------------------
  // request side
  // ----------------------------------------

  // valids only reach a unit while idle
  assign mul_req_val = req_val && !busy && !sel_div;
  assign div_req_val = req_val && !busy && sel_div;
  assign req_rdy     = !busy && (sel_div ? div_req_rdy : mul_req_rdy);

  // ----------------------------------------
  // response side
  // ----------------------------------------

  assign resp_msg     = owner ? div_resp_msg : mul_resp_msg;
  assign resp_val     = busy && (owner ? div_resp_val : mul_resp_val);
  assign mul_resp_rdy = busy && !owner && resp_rdy;
  assign div_resp_rdy = busy && owner && resp_rdy;

  // busy from accept to response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      owner <= 1'b0;
    end else if (!busy && req_val && req_rdy) begin
      busy  <= 1'b1;
      owner <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

endmodule

//--- hw/imuldiv_int_mul_iterative.sv
/* iterative signed multiplier
   shift-and-add on operand magnitudes, one bit per cycle, sign fixed at the end */

module imuldiv_int_mul_iterative (
  input  logic                            clk,
  input  logic                            reset,
  input  imuldiv_msg_pkg::muldiv_req_t     req_msg,
  input  logic                            req_val,
  output logic                            req_rdy,
  output imuldiv_msg_pkg::muldiv_result_u  resp_msg,
  output logic                            resp_val,
  input  logic                            resp_rdy
);

  import imuldiv_cfg_pkg::*;

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e                  state;
  logic [count_width-1:0]  count;

  // datapath registers
  logic [result_width-1:0] mcand_reg;
  logic [data_width-1:0]   mplier_reg;
  logic [result_width-1:0] acc_reg;
  logic                    neg_reg;

  logic [data_width-1:0]   a_mag;
  logic [data_width-1:0]   b_mag;
  logic                    req_go;

  // magnitudes of the incoming operands
  assign a_mag = req_msg.a[data_width-1] ? -req_msg.a : req_msg.a;
  assign b_mag = req_msg.b[data_width-1] ? -req_msg.b : req_msg.b;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign req_go   = req_val && req_rdy;

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: if (req_go) begin
          state <= st_calc;
          count <= '0;
        end
        // last step happens on the edge that leaves calc
        st_calc: if (count == count_width'(num_iters - 1)) begin
          state <= st_done;
        end else begin
          count <= count + 1'b1;
        end
        // hold result until the response transfer
        st_done: if (resp_rdy) begin
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand_reg  <= {{data_width{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      acc_reg    <= '0;
      neg_reg    <= req_msg.a[data_width-1] ^ req_msg.b[data_width-1];
    end else if (state == st_calc) begin
      // add shifted multiplicand when the current multiplier bit is set
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // product view, negated for mixed signs
  assign resp_msg.product = neg_reg ? -acc_reg : acc_reg;

endmodule

//--- div/imuldiv_int_div_iterative.sv
/* iterative divider
   joins the restoring divider datapath with its control FSM */

module imuldiv_int_div_iterative (
  input  logic                            clk,
  input  logic                            reset,
  input  imuldiv_msg_pkg::muldiv_req_t     req_msg,
  input  logic                            req_val,
  output logic                            req_rdy,
  output imuldiv_msg_pkg::muldiv_result_u  resp_msg,
  output logic                            resp_val,
  input  logic                            resp_rdy
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;

  imuldiv_int_div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .req_msg   (req_msg),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .resp_msg  (resp_msg)
  );

  // handshake status comes from the FSM only
  imuldiv_int_div_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel)
  );

endmodule

//--- div/imuldiv_int_div_dpath.sv
/* divider datapath
   restoring shift-and-subtract on magnitudes with sign correction on the output */

module imuldiv_int_div_dpath (
  input  logic                            clk,
  input  logic                            reset,
  input  imuldiv_msg_pkg::muldiv_req_t     req_msg,
  input  logic                            a_en,
  input  logic                            b_en,
  input  logic                            a_mux_sel,
  output imuldiv_msg_pkg::muldiv_result_u  resp_msg
);

  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;

  // remainder/quotient and divisor, one guard bit on top
  logic [result_width:0]   a_reg;
  logic [result_width:0]   b_reg;
  logic                    a_sign;
  logic                    b_sign;

  logic                    is_signed;
  logic                    a_sign_in;
  logic                    b_sign_in;
  logic [data_width-1:0]   a_mag;
  logic [data_width-1:0]   b_mag;
  logic [result_width:0]   init_a;
  logic [result_width:0]   init_b;
  logic [result_width:0]   a_shift;
  logic [result_width:0]   diff;
  logic [result_width:0]   step_out;
  logic [result_width:0]   a_mux_out;
  logic [data_width-1:0]   rem_mag;
  logic [data_width-1:0]   quot_mag;

  // ----------------------------------------
  // operand load
  // ----------------------------------------

  // unsigned divide ignores the sign bits
  assign is_signed = (req_msg.fn == fn_div);
  assign a_sign_in = is_signed && req_msg.a[data_width-1];
  assign b_sign_in = is_signed && req_msg.b[data_width-1];
  assign a_mag     = a_sign_in ? -req_msg.a : req_msg.a;
  assign b_mag     = b_sign_in ? -req_msg.b : req_msg.b;

  // dividend low, divisor aligned to the upper half
  assign init_a = {{(data_width + 1){1'b0}}, a_mag};
  assign init_b = {1'b0, b_mag, {data_width{1'b0}}};

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------

  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;
  // negative difference, keep the shifted value and a zero quotient bit
  assign step_out = diff[result_width] ? {a_shift[result_width:1], 1'b0}
                                       : {diff[result_width:1], 1'b1};

  assign a_mux_out = a_mux_sel ? step_out : init_a;

  always_ff @(posedge clk) begin
    if (reset) begin
      a_sign <= 1'b0;
      b_sign <= 1'b0;
    end else if (b_en) begin
      a_sign <= a_sign_in;
      b_sign <= b_sign_in;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= init_b;
    end
  end

  // ----------------------------------------
  // sign correction
  // ----------------------------------------

  assign rem_mag  = a_reg[result_width-1:data_width];
  assign quot_mag = a_reg[data_width-1:0];

  // quotient negative for mixed signs, remainder follows the dividend
  always_comb begin
    resp_msg.divrem.rem  = a_sign ? -rem_mag : rem_mag;
    resp_msg.divrem.quot = (a_sign ^ b_sign) ? -quot_mag : quot_mag;
  end

endmodule

//--- div/imuldiv_int_div_ctrl.sv
/* divider control
   idle/calc/done FSM with the iteration counter that steps the datapath */

module imuldiv_int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel
);

  import imuldiv_cfg_pkg::*;

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e                 state;
  logic [count_width-1:0] count;
  logic                   req_go;
  logic                   resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------
  // state and counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: if (req_go) begin
          state <= st_calc;
          count <= '0;
        end
        // num_iters steps, the last one on the leaving edge
        st_calc: if (count == count_width'(num_iters - 1)) begin
          state <= st_done;
        end else begin
          count <= count + 1'b1;
        end
        st_done: if (resp_go) begin
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  always_comb begin
    req_rdy   = 1'b0;
    resp_val  = 1'b0;
    a_en      = 1'b0;
    b_en      = 1'b0;
    a_mux_sel = 1'b0;
    case (state)
      // load both registers on accept
      st_idle: begin
        req_rdy = 1'b1;
        a_en    = req_go;
        b_en    = req_go;
      end
      // step the remainder register every cycle
      st_calc: begin
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
      end
      st_done: resp_val = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- common/imuldiv_msg_pkg.sv
/* imuldiv message formats
   function codes, request message and the two views of the result word */

package imuldiv_msg_pkg;

  // ----------------------------------------
  // function codes
  // ----------------------------------------

  // signed mul, signed div, unsigned div
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  // ----------------------------------------
  // request and response words
  // ----------------------------------------

  // request message, 66 bits
  typedef struct packed {
    muldiv_fn_e                                fn;
    logic [imuldiv_cfg_pkg::data_width-1:0]    a;
    logic [imuldiv_cfg_pkg::data_width-1:0]    b;
  } muldiv_req_t;

  // divider result layout, remainder on top
  typedef struct packed {
    logic [imuldiv_cfg_pkg::data_width-1:0] rem;
    logic [imuldiv_cfg_pkg::data_width-1:0] quot;
  } divrem_t;

  // one 64-bit response word, decoded by the unit that produced it
  typedef union packed {
    logic [imuldiv_cfg_pkg::result_width-1:0] product;
    divrem_t                                  divrem;
  } muldiv_result_u;

endpackage

//--- common/imuldiv_cfg_pkg.sv
/* imuldiv sizing constants
   operand and result widths and the iteration count of the iterative units */

package imuldiv_cfg_pkg;

  // operand width of one source register
  localparam int data_width = 32;

  // full result word, product or remainder/quotient pair
  localparam int result_width = 2 * data_width;

  // one result bit per cycle
  localparam int num_iters = data_width;

  // iteration counter width, one spare bit above num_iters - 1
  localparam int count_width = $clog2(num_iters + 1);

endpackage
